/* common/cpuIdPkg.sv */
package cpuIdPkg;

	// basic widths
	localparam int WordWidth = 64;
	localparam int IndexWidth = 5;
	localparam int TimerWidth = 12;
	localparam int RngWidth = 32;
	localparam int FeatureWidth = 21;
	localparam int TickCountWidth = 4;

	typedef logic [WordWidth-1:0] word64_t;
	typedef logic [IndexWidth-1:0] cpuIdIndex_t;
	typedef logic [TimerWidth-1:0] timerVec_t;
	typedef logic [RngWidth-1:0] rngWord_t;
	typedef logic [0:0] laneId_t;

	// request held by a lane while it waits for the unit
	typedef struct packed {
		cpuIdIndex_t index;
	} cpuIdReq_t;

	// hi is reserved and reads as zero
	typedef struct packed {
		word64_t lo;
		word64_t hi;
	} cpuIdResult_t;

	// ASCII "BJX2F2  " with the first character in the low byte
	localparam word64_t IdString = 64'h2020_3246_3258_4A42;

	// feature bits placed at bits 24..4 of the feature word
	// bit 4 (word bit 8)   wide execute
	// bit 7 (word bit 11)  MMU
	// bit 11 (word bit 15) FPU
	// bit 14 (word bit 18) fused multiply-add
	// bit 15 (word bit 19) wide ALU
	localparam logic [FeatureWidth-1:0] FeatureMask = 21'h00_C890;

	// cycles between timer ticks
	// timers[0] is high for one cycle in each period
	// and the tick counter advances on that same cycle
	localparam int TickDivide = 8;
	localparam int PrescaleWidth = $clog2(TickDivide);

	// number of execute lanes sharing the unit
	localparam int NumLanes = 2;

	// nonzero LFSR seeds so the registers never start stuck
	localparam rngWord_t RngSeedA = 32'h1F2E_3D4C;
	localparam rngWord_t RngSeedB = 32'hA5C3_9617;

endpackage

/* verilog/timerUnit.sv */
`timescale 1ns/100ps

module timerUnit import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	output timerVec_t timers
);

	logic [PrescaleWidth-1:0] prescale;
	logic [TickCountWidth-1:0] tickCount;
	logic tickPulse;

	// last cycle of each prescaler period
	assign tickPulse = (prescale == PrescaleWidth'(TickDivide - 1));

	always_ff @(posedge clock) begin
		if (!rstN) begin
			prescale <= '0;
		end else if (tickPulse) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// wraps every 16 ticks, only the low nibble is visible
	always_ff @(posedge clock) begin
		if (!rstN) begin
			tickCount <= '0;
		end else if (tickPulse) begin
			tickCount <= tickCount + 1'b1;
		end
	end

	// nibble on top, tick pulse in bit 0, middle bits unused
	assign timers = {
		tickCount,
		{(TimerWidth - TickCountWidth - 1){1'b0}},
		tickPulse
	};

endmodule

/* cpuid/entropySource.sv */
`timescale 1ns/100ps

module entropySource import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	input logic noiseIn,
	output rngWord_t rngA,
	output rngWord_t rngB
);

	logic noiseSync1;
	logic noiseSync2;
	logic noiseEdge;
	logic feedA;
	logic feedB;
	logic feedALast;
	logic feedBLast;

	// each register is stirred by the other's previous feedback bit
	assign feedA = rngA[1] ^ rngA[3] ^ rngA[5] ^ rngA[7] ^ noiseEdge ^ feedBLast ^ 1'b1;
	assign feedB = rngB[1] ^ rngB[3] ^ rngB[5] ^ rngB[7] ^ noiseEdge ^ feedALast ^ 1'b1;

	// noise synchroniser, last stage is an edge detector
	always_ff @(posedge clock) begin
		if (!rstN) begin
			noiseSync1 <= 1'b0;
			noiseSync2 <= 1'b0;
			noiseEdge <= 1'b0;
		end else begin
			noiseSync1 <= noiseIn;
			noiseSync2 <= noiseSync1;
			noiseEdge <= noiseSync2 ^ noiseSync1;
		end
	end

	// shift right, new bit enters at the top
	always_ff @(posedge clock) begin
		if (!rstN) begin
			rngA <= RngSeedA;
			rngB <= RngSeedB;
			feedALast <= 1'b0;
			feedBLast <= 1'b0;
		end else begin
			rngA <= {feedA, rngA[RngWidth-1:1]};
			rngB <= {feedB, rngB[RngWidth-1:1]};
			feedALast <= feedA;
			feedBLast <= feedB;
		end
	end

endmodule

/* cpuid/cpuIdUnit.sv */
`timescale 1ns/100ps

module cpuIdUnit import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	input logic selStrobe,
	input cpuIdReq_t selReq,
	input laneId_t selLane,
	input timerVec_t timers,
	input rngWord_t rngA,
	input rngWord_t rngB,
	output logic resultValid,
	output laneId_t resultLane,
	output cpuIdResult_t result
);

	word64_t featureWord;
	word64_t entropyWord;
	word64_t lookupLo;

	// feature mask above, timer nibble in the low four bits
	assign featureWord = word64_t'({FeatureMask, timers[TimerWidth-1 -: TickCountWidth]});

	// nibbles of A from the top down, interleaved with nibbles of B from the bottom up
	always_comb begin
		entropyWord = '0;
		for (int i = 0; i < 8; i++) begin
			entropyWord[63 - 8*i -: 8] = {rngA[31 - 4*i -: 4], rngB[4*i +: 4]};
		end
	end

	// leaf decode
	always_comb begin
		case (selReq.index)
			5'd0: begin
				lookupLo = IdString;
			end
			5'd1: begin
				lookupLo = featureWord;
			end
			5'd31: begin
				lookupLo = entropyWord;
			end
			default: begin
				// leaves 2..30 are reserved
				lookupLo = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= selStrobe;
		end
	end

	// result and its lane tag, captured in the grant cycle
	always_ff @(posedge clock) begin
		if (selStrobe) begin
			resultLane <= selLane;
			result.lo <= lookupLo;
			result.hi <= '0;
		end
	end

endmodule

/* verilog/requestLane.sv */
`timescale 1ns/100ps

module requestLane import cpuIdPkg::*; #(
	parameter laneId_t LaneNumber = '0
) (
	input logic clock,
	input logic rstN,
	input logic reqStrobe,
	input cpuIdIndex_t reqIndex,
	input logic grant,
	input logic resultValid,
	input laneId_t resultLane,
	input cpuIdResult_t result,
	output logic pending,
	output cpuIdReq_t heldReq,
	output logic busy,
	output logic respValid,
	output cpuIdResult_t respData
);

	logic accept;

	// strobes arriving while busy are dropped
	assign accept = reqStrobe && !busy;

	// result addressed to this lane, passed straight through
	assign respValid = resultValid && (resultLane == LaneNumber);
	assign respData = result;

	always_ff @(posedge clock) begin
		if (accept) begin
			heldReq.index <= reqIndex;
		end
	end

	// pending until granted, busy until the response
	always_ff @(posedge clock) begin
		if (!rstN) begin
			pending <= 1'b0;
			busy <= 1'b0;
		end else begin
			if (accept) begin
				pending <= 1'b1;
				busy <= 1'b1;
			end else begin
				if (grant) begin
					pending <= 1'b0;
				end
				if (respValid) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

/* verilog/cpuIdArbiter.sv */
`timescale 1ns/100ps

module cpuIdArbiter import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	input logic [NumLanes-1:0] pending,
	input cpuIdReq_t heldReq [NumLanes],
	output logic [NumLanes-1:0] grant,
	output logic selStrobe,
	output cpuIdReq_t selReq,
	output laneId_t selLane
);

	laneId_t lastWinner;
	logic contested;

	// search starts at the lane after the last contested winner
	always_comb begin
		laneId_t candidate;
		logic found;
		found = 1'b0;
		selLane = lastWinner;
		for (int offset = 1; offset <= NumLanes; offset++) begin
			candidate = laneId_t'((int'(lastWinner) + offset) % NumLanes);
			if (!found && pending[candidate]) begin
				selLane = candidate;
				found = 1'b1;
			end
		end
	end

	assign selStrobe = |pending;
	assign contested = ($countones(pending) > 1);
	assign selReq = heldReq[selLane];

	always_comb begin
		grant = '0;
		if (selStrobe) begin
			grant[selLane] = 1'b1;
		end
	end

	// pointer moves only when lanes compete, so contested winners alternate
	always_ff @(posedge clock) begin
		if (!rstN) begin
			lastWinner <= laneId_t'(NumLanes - 1);
		end else if (contested) begin
			lastWinner <= selLane;
		end
	end

endmodule

/* verilog/cpuIdSubsystem.sv */
`timescale 1ns/100ps

module cpuIdSubsystem import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	input logic [NumLanes-1:0] reqStrobe,
	input cpuIdIndex_t reqIndex [NumLanes],
	output logic [NumLanes-1:0] busy,
	output logic [NumLanes-1:0] respValid,
	output cpuIdResult_t respData [NumLanes]
);

	timerVec_t timers;
	rngWord_t rngA;
	rngWord_t rngB;
	logic [NumLanes-1:0] lanePending;
	logic [NumLanes-1:0] laneGrant;
	cpuIdReq_t laneReq [NumLanes];
	logic selStrobe;
	cpuIdReq_t selReq;
	laneId_t selLane;
	logic resultValid;
	laneId_t resultLane;
	cpuIdResult_t result;

	timerUnit timer (
		.clock(clock),
		.rstN(rstN),
		.timers(timers)
	);

	// tick pulse doubles as the noise input
	entropySource entropy (
		.clock(clock),
		.rstN(rstN),
		.noiseIn(timers[0]),
		.rngA(rngA),
		.rngB(rngB)
	);

	for (genvar i = 0; i < NumLanes; i++) begin : gLane
		requestLane #(
			.LaneNumber(laneId_t'(i))
		) lane (
			.clock(clock),
			.rstN(rstN),
			.reqStrobe(reqStrobe[i]),
			.reqIndex(reqIndex[i]),
			.grant(laneGrant[i]),
			.resultValid(resultValid),
			.resultLane(resultLane),
			.result(result),
			.pending(lanePending[i]),
			.heldReq(laneReq[i]),
			.busy(busy[i]),
			.respValid(respValid[i]),
			.respData(respData[i])
		);
	end

	cpuIdArbiter arbiter (
		.clock(clock),
		.rstN(rstN),
		.pending(lanePending),
		.heldReq(laneReq),
		.grant(laneGrant),
		.selStrobe(selStrobe),
		.selReq(selReq),
		.selLane(selLane)
	);

	cpuIdUnit unit (
		.clock(clock),
		.rstN(rstN),
		.selStrobe(selStrobe),
		.selReq(selReq),
		.selLane(selLane),
		.timers(timers),
		.rngA(rngA),
		.rngB(rngB),
		.resultValid(resultValid),
		.resultLane(resultLane),
		.result(result)
	);

endmodule

/* verif/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
	parameter int PeriodNs = 4,
	parameter int ResetCycles = 16
) (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever begin
			#(PeriodNs / 2.0) clock = ~clock;
		end
	end

	// released on a falling edge, the first active edge sees a settled reset
	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
	end

endmodule

/* verif/cpuIdSubsystem_assertions.sv */
`timescale 1ns/100ps

module arbiterAssertions import cpuIdPkg::*; (
	input logic clock,
	input logic rstN,
	input logic [NumLanes-1:0] pending,
	input logic [NumLanes-1:0] grant
);

	int failCount = 0;

	grantOneHot: assert property (@(posedge clock) disable iff (!rstN) $onehot0(grant))
		else begin
			$error("more than one lane granted at once: %b", grant);
			failCount++;
		end

	// a grant never goes to an idle lane
	grantToPending: assert property (@(posedge clock) disable iff (!rstN) (grant & ~pending) == '0)
		else begin
			$error("grant %b given to a lane that is not pending (%b)", grant, pending);
			failCount++;
		end

	for (genvar i = 0; i < NumLanes; i++) begin : gLaneCheck
		grantInTime: assert property (
			@(posedge clock) disable iff (!rstN) pending[i] |-> ##[0:2] grant[i]
		) else begin
			$error("lane %0d stayed pending for more than two cycles", i);
			failCount++;
		end
	end

endmodule

/* verif/cpuIdSubsystemTb.sv */
`timescale 1ns/100ps

module cpuIdSubsystemTb import cpuIdPkg::*; ();

	localparam int PeriodNs = 4;
	localparam int ResetCycles = 16;
	localparam int NumRandom = 40;
	localparam int NumContested = 4;
	// directed requests are 4 fixed leaves, 29 reserved, 4 entropy reads and 1 busy strobe
	localparam int NumRequests = 38 + 2 * NumContested + NumRandom;
	localparam int TimeoutCycles = NumRequests * 8 + ResetCycles;
	localparam int RespWaitCycles = 8;

	logic clock;
	logic rstN;
	logic [NumLanes-1:0] reqStrobe;
	cpuIdIndex_t reqIndex [NumLanes];
	logic [NumLanes-1:0] busy;
	logic [NumLanes-1:0] respValid;
	cpuIdResult_t respData [NumLanes];

	logic [31:0] lfsrState = 32'he4ff3c0e;
	int edgeCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int lastWinner = -1;
	logic [NumLanes-1:0] outstanding = '0;
	cpuIdIndex_t expIndex [NumLanes];
	int strobeEdge [NumLanes];
	int latency [NumLanes];
	word64_t lastEntropy = '0;

	clockGen #(.PeriodNs(PeriodNs), .ResetCycles(ResetCycles)) clocks (
		.clock(clock),
		.rstN(rstN)
	);

	cpuIdSubsystem UUT (
		.clock(clock),
		.rstN(rstN),
		.reqStrobe(reqStrobe),
		.reqIndex(reqIndex),
		.busy(busy),
		.respValid(respValid),
		.respData(respData)
	);

	bind cpuIdArbiter arbiterAssertions arbiterChecks (
		.clock(clock),
		.rstN(rstN),
		.pending(pending),
		.grant(grant)
	);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	// expected result for every leaf except 31 from the ticks seen at the grant
	function automatic cpuIdResult_t refResult(input cpuIdIndex_t index,
			input int edgesAtGrant);
		cpuIdResult_t res;
		logic [3:0] nibble;
		nibble = 4'((edgesAtGrant / TickDivide) % 16);
		res.hi = '0;
		res.lo = '0;
		if (index == 5'd0) begin
			res.lo = IdString;
		end else if (index == 5'd1) begin
			res.lo = {39'b0, FeatureMask, nibble};
		end
		return res;
	endfunction

	always @(posedge clock) begin
		if (rstN) begin
			edgeCount <= edgeCount + 1;
		end
	end

	// busy of every lane in every cycle and each response against the reference
	always @(negedge clock) begin
		cpuIdResult_t expected;
		logic expBusy;
		if (rstN) begin
			for (int lane = 0; lane < NumLanes; lane++) begin
				expBusy = outstanding[lane] && (edgeCount >= strobeEdge[lane]);
				checkCount++;
				if (busy[lane] !== expBusy) begin
					$display("[ERROR] busy[%0d]: expected %h, got %h",
						lane, expBusy, busy[lane]);
					errorCount++;
				end
				if (respValid[lane] !== 1'b0 && !outstanding[lane]) begin
					$display("lane %0d gave a response with no request open", lane);
					errorCount++;
				end else if (respValid[lane] === 1'b1) begin
					latency[lane] = edgeCount + 1 - strobeEdge[lane];
					expected = refResult(expIndex[lane], edgeCount - 1);
					if (expIndex[lane] == 5'd31) begin
						if ($isunknown(respData[lane].lo) || respData[lane].lo == '0
								|| respData[lane].lo == lastEntropy) begin
							$display("entropy read on lane %0d returned %h, zero or a repeat",
								lane, respData[lane].lo);
							errorCount++;
						end
						lastEntropy = respData[lane].lo;
					end else if (respData[lane].lo !== expected.lo) begin
						$display("[ERROR] respData[%0d].lo: index %0d expected %h, got %h",
							lane, expIndex[lane], expected.lo, respData[lane].lo);
						errorCount++;
					end
					if (respData[lane].hi !== expected.hi) begin
						$display("[ERROR] respData[%0d].hi: expected %h, got %h",
							lane, expected.hi, respData[lane].hi);
						errorCount++;
					end
					outstanding[lane] = 1'b0;
				end
			end
		end
	end

	task automatic startRequest(input int lane, input cpuIdIndex_t index);
		reqStrobe[lane] = 1'b1;
		reqIndex[lane] = index;
		expIndex[lane] = index;
		strobeEdge[lane] = edgeCount + 1;
		latency[lane] = 0;
		outstanding[lane] = 1'b1;
	endtask

	// waits on rising edges while the comparer clears outstanding on falling ones
	task automatic waitDone(input int lane);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (outstanding[lane] && cycles < RespWaitCycles);
		if (outstanding[lane]) begin
			$display("lane %0d got no response within %0d cycles", lane, RespWaitCycles);
			errorCount++;
			outstanding[lane] = 1'b0;
		end
	endtask

	task automatic issueRequest(input int lane, input cpuIdIndex_t index);
		@(negedge clock);
		startRequest(lane, index);
		@(negedge clock);
		reqStrobe = '0;
		waitDone(lane);
		if (latency[lane] != 2) begin
			$display("lane %0d answered %0d edges after its strobe instead of 2",
				lane, latency[lane]);
			errorCount++;
		end
	endtask

	// both lanes strobe at once and the winner alternates from pair to pair
	task automatic contestedPair(input cpuIdIndex_t index0, input cpuIdIndex_t index1);
		int winner;
		@(negedge clock);
		startRequest(0, index0);
		startRequest(1, index1);
		@(negedge clock);
		reqStrobe = '0;
		waitDone(0);
		waitDone(1);
		if (latency[0] + latency[1] != 5 || (latency[0] != 2 && latency[1] != 2)) begin
			$display("contested pair answered after %0d and %0d edges, not 2 and 3",
				latency[0], latency[1]);
			errorCount++;
		end else begin
			winner = (latency[0] == 2) ? 0 : 1;
			if (winner == lastWinner) begin
				$display("lane %0d won two contested pairs in a row", winner);
				errorCount++;
			end
			lastWinner = winner;
		end
	endtask

	initial begin
		int lane;
		cpuIdIndex_t index;
		int assertFails;
		reqStrobe = '0;
		for (int i = 0; i < NumLanes; i++) begin
			reqIndex[i] = '0;
			expIndex[i] = '0;
			strobeEdge[i] = 0;
			latency[i] = 0;
		end
		wait (rstN === 1'b1);
		// no requests for a few cycles after reset
		repeat (5) @(negedge clock);
		for (int i = 0; i < 4; i++) begin
			issueRequest(i % 2, cpuIdIndex_t'(i / 2));
		end
		for (int i = 2; i <= 30; i++) begin
			issueRequest(i % 2, cpuIdIndex_t'(i));
		end
		for (int i = 0; i < 4; i++) begin
			issueRequest(i % 2, 5'd31);
		end
		// two more strobes land while lane 0 is busy and must be dropped
		@(negedge clock);
		startRequest(0, 5'd0);
		repeat (2) begin
			@(negedge clock);
			reqStrobe[0] = 1'b1;
			reqIndex[0] = 5'd1;
		end
		@(negedge clock);
		reqStrobe = '0;
		waitDone(0);
		repeat (6) @(negedge clock);
		for (int i = 0; i < NumContested; i++) begin
			contestedPair(cpuIdIndex_t'(i % 2), cpuIdIndex_t'(1 - i % 2));
		end
		for (int n = 0; n < NumRandom; n++) begin
			lane = int'(randomBits(1));
			case (randomBits(2))
				0: index = 5'd0;
				1: index = 5'd1;
				2: index = 5'd31;
				default: index = cpuIdIndex_t'(randomBits(5));
			endcase
			issueRequest(lane, index);
		end
		repeat (4) @(negedge clock);
		assertFails = UUT.arbiter.arbiterChecks.failCount;
		$display("checks: %0d  errors: %0d  assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(TimeoutCycles * PeriodNs);
		$display("watchdog expired after %0d cycles with %0d errors",
			TimeoutCycles, errorCount);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* filelist.f */
common/cpuIdPkg.sv
verilog/timerUnit.sv
cpuid/entropySource.sv
cpuid/cpuIdUnit.sv
verilog/requestLane.sv
verilog/cpuIdArbiter.sv
verilog/cpuIdSubsystem.sv
verif/clockGen.sv
verif/cpuIdSubsystem_assertions.sv
verif/cpuIdSubsystemTb.sv

/* Bender.yml */
package:
  name: cpu_id_subsystem

sources:
  - common/cpuIdPkg.sv
  - verilog/timerUnit.sv
  - cpuid/entropySource.sv
  - cpuid/cpuIdUnit.sv
  - verilog/requestLane.sv
  - verilog/cpuIdArbiter.sv
  - verilog/cpuIdSubsystem.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/cpuIdSubsystem_assertions.sv
      - verif/cpuIdSubsystemTb.sv
